/* bridge/periph_bridge.sv */
`timescale 1ns/1ns

module periph_bridge #(
	parameter int FREQUENCY = 100_000_000,
	parameter int RAM_ADDR_BITS = 10,
	parameter int DEVICE_ID = 6
)(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input soc_pkg::bus_addr_u i_address,
	input logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_timer_interrupt,
	output logic [7:0] o_leds
);
	import soc_pkg::*;

	logic far_request;
	logic far_rw;
	bus_addr_u far_address;
	logic [DATA_W-1:0] far_wdata;
	logic [3:0] far_reg_index;
	logic [DATA_W-1:0] far_rdata;
	logic far_ready;

	logic timer_select;
	logic sysreg_select;
	logic unmapped_ready;
	logic [DATA_W-1:0] timer_rdata;
	logic timer_ready;
	logic [DATA_W-1:0] sysreg_rdata;
	logic sysreg_ready;

	// ====================
	// Near side
	// ====================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			far_request <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			if (far_request) begin
				if (far_ready)
					far_request <= 1'b0;
			end else if (i_request && !o_ready) begin
				far_request <= 1'b1;
			end
			o_ready <= far_request && far_ready;
		end
	end

	// Far fields and the returned word
	always_ff @(posedge clock) begin
		if (!far_request && i_request) begin
			far_rw <= i_rw;
			far_address <= i_address;
			far_wdata <= i_wdata;
		end
		if (far_request && far_ready)
			o_rdata <= far_rdata;
	end

	// ====================
	// Far side
	// ====================

	assign far_reg_index = far_address.far.reg_offset[REG_INDEX_LSB+3:REG_INDEX_LSB];
	assign timer_select = far_address.far.device == DEVICE_TIMER;
	assign sysreg_select = far_address.far.device == DEVICE_SYSREG;

	// No device at this slot
	always_ff @(posedge clock) begin
		if (i_reset)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= far_request && !timer_select && !sysreg_select &&
				!unmapped_ready;
	end

	timer #(
		.FREQUENCY(FREQUENCY)
	) timer_inst(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(far_request && timer_select),
		.i_rw(far_rw),
		.i_reg_index(far_reg_index),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

	system_registers #(
		.RAM_ADDR_BITS(RAM_ADDR_BITS),
		.DEVICE_ID(DEVICE_ID)
	) sysreg_inst(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(far_request && sysreg_select),
		.i_rw(far_rw),
		.i_reg_index(far_reg_index),
		.i_wdata(far_wdata),
		.o_rdata(sysreg_rdata),
		.o_ready(sysreg_ready),
		.o_leds(o_leds)
	);

	assign far_rdata =
		timer_select ? timer_rdata :
		sysreg_select ? sysreg_rdata :
		'0;

	assign far_ready =
		timer_select ? timer_ready :
		sysreg_select ? sysreg_ready :
		unmapped_ready;

endmodule

/* bridge/system_registers.sv */
`timescale 1ns/1ns

module system_registers #(
	parameter int RAM_ADDR_BITS = 10,
	parameter int DEVICE_ID = 6
)(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_reg_index,
	input logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic [7:0] o_leds
);
	import soc_pkg::*;

	// Scratch RAM size in bytes
	localparam logic [31:0] RAM_SIZE_BYTES = 32'(4 * (2 ** RAM_ADDR_BITS));

	// LED register and the ready pulse
	always_ff @(posedge clock) begin
		if (i_reset) begin
			o_leds <= 8'd0;
			o_ready <= 1'b0;
		end else begin
			if (i_request && i_rw && !o_ready && i_reg_index == SYSREG_REG_LEDS)
				o_leds <= i_wdata[7:0];
			o_ready <= i_request && !o_ready;
		end
	end

	// Read mux
	always_ff @(posedge clock) begin
		if (i_request) begin
			case (i_reg_index)
				SYSREG_REG_ID: o_rdata <= DATA_W'(DEVICE_ID);
				SYSREG_REG_RAM_SIZE: o_rdata <= RAM_SIZE_BYTES;
				SYSREG_REG_LEDS: o_rdata <= {24'd0, o_leds};
				default: o_rdata <= '0;
			endcase
		end
	end

endmodule

/* bridge/timer.sv */
`timescale 1ns/1ns

module timer #(
	parameter int FREQUENCY = 100_000_000
)(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [3:0] i_reg_index,
	input logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready,
	output logic o_interrupt
);
	import soc_pkg::*;

	// Clock cycles per microsecond
	localparam int TICK_CYCLES = FREQUENCY / 1_000_000;

	logic [31:0] prescale;
	logic [31:0] count;
	logic [31:0] compare;
	logic enable;

	// ====================
	// Microsecond count
	// ====================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			prescale <= '0;
			count <= '0;
		end else if (prescale == 32'(TICK_CYCLES - 1)) begin
			prescale <= '0;
			count <= count + 32'd1;
		end else begin
			prescale <= prescale + 32'd1;
		end
	end

	// ====================
	// Register access
	// ====================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			compare <= '1;
			enable <= 1'b0;
			o_ready <= 1'b0;
		end else begin
			// Count itself is read only
			if (i_request && i_rw && !o_ready) begin
				if (i_reg_index == TIMER_REG_COMPARE)
					compare <= i_wdata;
				else if (i_reg_index == TIMER_REG_CONTROL)
					enable <= i_wdata[0];
			end
			o_ready <= i_request && !o_ready;
		end
	end

	always_ff @(posedge clock) begin
		if (i_request) begin
			case (i_reg_index)
				TIMER_REG_COUNT: o_rdata <= count;
				TIMER_REG_COMPARE: o_rdata <= compare;
				TIMER_REG_CONTROL: o_rdata <= {31'd0, enable};
				default: o_rdata <= '0;
			endcase
		end
	end

	// Level interrupt until compare moves past count
	assign o_interrupt = enable && (count >= compare);

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

	// ====================
	// Bus widths
	// ====================

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;

	// ====================
	// Address map
	// ====================

	// Top nibble of the system address
	localparam logic [3:0] REGION_RAM = 4'h2;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	// Device field behind the bridge
	localparam logic [3:0] DEVICE_TIMER = 4'h5;
	localparam logic [3:0] DEVICE_SYSREG = 4'h9;

	// Registers sit one word apart
	localparam int REG_INDEX_LSB = 2;

	// Same address word seen from the system bus and from the far bus
	typedef union packed {
		struct packed {
			logic [3:0] region;
			logic [ADDR_W-5:0] offset;
		} main;
		struct packed {
			logic [3:0] region;
			logic [3:0] device;
			logic [ADDR_W-9:0] reg_offset;
		} far;
	} bus_addr_u;

	// Timer register indices
	localparam logic [3:0] TIMER_REG_COUNT = 4'd0;
	localparam logic [3:0] TIMER_REG_COMPARE = 4'd1;
	localparam logic [3:0] TIMER_REG_CONTROL = 4'd2;

	// System register indices
	localparam logic [3:0] SYSREG_REG_ID = 4'd0;
	localparam logic [3:0] SYSREG_REG_RAM_SIZE = 4'd1;
	localparam logic [3:0] SYSREG_REG_LEDS = 4'd2;

endpackage

/* design/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter(
	input logic clock,
	input logic i_reset,

	// Port A is the instruction side and only reads
	input logic i_pa_request,
	input logic [soc_pkg::ADDR_W-1:0] i_pa_address,
	output logic [soc_pkg::DATA_W-1:0] o_pa_rdata,
	output logic o_pa_ready,

	// Port B is the data side
	input logic i_pb_request,
	input logic i_pb_rw,
	input logic [soc_pkg::ADDR_W-1:0] i_pb_address,
	input logic [soc_pkg::DATA_W-1:0] i_pb_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_pb_rdata,
	output logic o_pb_ready,

	// System bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output logic [soc_pkg::ADDR_W-1:0] o_bus_address,
	output logic [soc_pkg::DATA_W-1:0] o_bus_wdata,
	input logic [soc_pkg::DATA_W-1:0] i_bus_rdata,
	input logic i_bus_ready
);

	localparam logic [1:0] GRANT_IDLE = 2'd0;
	localparam logic [1:0] GRANT_A = 2'd1;
	localparam logic [1:0] GRANT_B = 2'd2;

	logic [1:0] grant;

	// ====================
	// Grant register
	// ====================

	always_ff @(posedge clock) begin
		if (i_reset) begin
			grant <= GRANT_IDLE;
		end else begin
			case (grant)
				GRANT_IDLE: begin
					// Data port wins a tie
					if (i_pb_request)
						grant <= GRANT_B;
					else if (i_pa_request)
						grant <= GRANT_A;
				end
				default: begin
					// Back to idle on the ready edge
					if (i_bus_ready)
						grant <= GRANT_IDLE;
				end
			endcase
		end
	end

	// ====================
	// Routing
	// ====================

	always_comb begin
		o_bus_request = (grant == GRANT_A && i_pa_request) ||
			(grant == GRANT_B && i_pb_request);
		o_bus_rw = (grant == GRANT_B) ? i_pb_rw : 1'b0;
		o_bus_address = (grant == GRANT_B) ? i_pb_address : i_pa_address;
		o_bus_wdata = (grant == GRANT_B) ? i_pb_wdata : '0;

		// Response goes only to the port that holds the grant
		o_pa_ready = (grant == GRANT_A) && i_bus_ready;
		o_pb_ready = (grant == GRANT_B) && i_bus_ready;
		o_pa_rdata = (grant == GRANT_A) ? i_bus_rdata : '0;
		o_pb_rdata = (grant == GRANT_B) ? i_bus_rdata : '0;
	end

endmodule

/* design/scratch_ram.sv */
`timescale 1ns/1ns

module scratch_ram #(
	parameter int RAM_ADDR_BITS = 10
)(
	input logic clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input logic [RAM_ADDR_BITS+1:0] i_address,
	input logic [soc_pkg::DATA_W-1:0] i_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_rdata,
	output logic o_ready
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [2**RAM_ADDR_BITS];
	logic [RAM_ADDR_BITS-1:0] word_index;

	// Byte address in, word index out
	assign word_index = i_address[RAM_ADDR_BITS+1:2];

	// Storage and registered read
	always_ff @(posedge clock) begin
		if (i_request) begin
			if (i_rw)
				mem[word_index] <= i_wdata;
			o_rdata <= mem[word_index];
		end
	end

	// One pulse per request even if it is still held
	always_ff @(posedge clock) begin
		if (i_reset)
			o_ready <= 1'b0;
		else
			o_ready <= i_request && !o_ready;
	end

endmodule

/* design/soc_top.sv */
`timescale 1ns/1ns

module soc_top #(
	parameter int FREQUENCY = 100_000_000,
	parameter int RAM_ADDR_BITS = 10,
	parameter int DEVICE_ID = 6
)(
	input logic clock,
	input logic i_reset,

	// Instruction port
	input logic i_pa_request,
	input logic [soc_pkg::ADDR_W-1:0] i_pa_address,
	output logic [soc_pkg::DATA_W-1:0] o_pa_rdata,
	output logic o_pa_ready,

	// Data port
	input logic i_pb_request,
	input logic i_pb_rw,
	input logic [soc_pkg::ADDR_W-1:0] i_pb_address,
	input logic [soc_pkg::DATA_W-1:0] i_pb_wdata,
	output logic [soc_pkg::DATA_W-1:0] o_pb_rdata,
	output logic o_pb_ready,

	output logic o_timer_interrupt,
	output logic [7:0] o_leds
);
	import soc_pkg::*;

	logic bus_request;
	logic bus_rw;
	logic [ADDR_W-1:0] bus_address;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;
	logic bus_ready;

	bus_addr_u bus_addr_view;
	logic ram_select;
	logic bridge_select;
	logic [DATA_W-1:0] ram_rdata;
	logic ram_ready;
	logic [DATA_W-1:0] bridge_rdata;
	logic bridge_ready;
	logic unmapped_ready;

	bus_arbiter arbiter(
		.clock(clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_rdata(o_pa_rdata),
		.o_pa_ready(o_pa_ready),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_rdata(o_pb_rdata),
		.o_pb_ready(o_pb_ready),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.i_bus_rdata(bus_rdata),
		.i_bus_ready(bus_ready)
	);

	// ====================
	// Region decode
	// ====================

	assign bus_addr_view = bus_address;
	assign ram_select = bus_addr_view.main.region == REGION_RAM;
	assign bridge_select = bus_addr_view.main.region == REGION_BRIDGE;

	// Anything else answers with zero
	always_ff @(posedge clock) begin
		if (i_reset)
			unmapped_ready <= 1'b0;
		else
			unmapped_ready <= bus_request && !ram_select && !bridge_select &&
				!unmapped_ready;
	end

	scratch_ram #(
		.RAM_ADDR_BITS(RAM_ADDR_BITS)
	) ram(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(bus_request && ram_select),
		.i_rw(bus_rw),
		.i_address(bus_addr_view.main.offset[RAM_ADDR_BITS+1:0]),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	periph_bridge #(
		.FREQUENCY(FREQUENCY),
		.RAM_ADDR_BITS(RAM_ADDR_BITS),
		.DEVICE_ID(DEVICE_ID)
	) bridge(
		.clock(clock),
		.i_reset(i_reset),
		.i_request(bus_request && bridge_select),
		.i_rw(bus_rw),
		.i_address(bus_addr_view),
		.i_wdata(bus_wdata),
		.o_rdata(bridge_rdata),
		.o_ready(bridge_ready),
		.o_timer_interrupt(o_timer_interrupt),
		.o_leds(o_leds)
	);

	assign bus_rdata =
		ram_select ? ram_rdata :
		bridge_select ? bridge_rdata :
		'0;

	assign bus_ready =
		ram_select ? ram_ready :
		bridge_select ? bridge_ready :
		unmapped_ready;

endmodule

/* flist.f */
+incdir+sim
common/soc_pkg.sv
design/bus_arbiter.sv
design/scratch_ram.sv
bridge/timer.sv
bridge/system_registers.sv
bridge/periph_bridge.sv
design/soc_top.sv
sim/soc_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module soc_tb --Mdir obj_dir -o soc_sim &&
./obj_dir/soc_sim ||
{ echo "Simulation build or run failed"; exit 1; }

/* sim/soc_tb_table.svh */
`ifndef SOC_TB_TABLE_SVH
`define SOC_TB_TABLE_SVH

// Each entry gives port, rw, address, write data, expected read data and the paired flag
// A paired entry is issued together with the next entry on the other port

localparam logic PORT_A = 1'b0;
localparam logic PORT_B = 1'b1;
localparam logic RW_READ = 1'b0;
localparam logic RW_WRITE = 1'b1;

typedef struct packed {
	logic port;
	logic rw;
	logic [31:0] address;
	logic [31:0] wdata;
	logic [31:0] expected;
	logic paired;
} stim_entry_t;

localparam int TABLE_LEN = 18;

localparam stim_entry_t STIMULUS [0:TABLE_LEN-1] = '{
	// RAM through both ports
	'{PORT_B, RW_WRITE, 32'h2000_0010, 32'hCAFE_0001, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_READ, 32'h2000_0010, 32'h0000_0000, 32'hCAFE_0001, 1'b0},
	'{PORT_A, RW_READ, 32'h2000_0010, 32'h0000_0000, 32'hCAFE_0001, 1'b0},
	// Same-cycle requests on A and B
	'{PORT_B, RW_WRITE, 32'h2000_0020, 32'h1111_2222, 32'h0000_0000, 1'b0},
	'{PORT_A, RW_READ, 32'h2000_0020, 32'h0000_0000, 32'h1111_2222, 1'b1},
	'{PORT_B, RW_WRITE, 32'h2000_0024, 32'h3333_4444, 32'h0000_0000, 1'b0},
	'{PORT_A, RW_READ, 32'h2000_0024, 32'h0000_0000, 32'h3333_4444, 1'b0},
	// System registers
	'{PORT_B, RW_READ, 32'h5900_0000, 32'h0000_0000, 32'h0000_0006, 1'b0},
	'{PORT_B, RW_READ, 32'h5900_0004, 32'h0000_0000, 32'h0000_1000, 1'b0},
	'{PORT_B, RW_WRITE, 32'h5900_0008, 32'h0000_01A5, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_READ, 32'h5900_0008, 32'h0000_0000, 32'h0000_00A5, 1'b0},
	'{PORT_A, RW_READ, 32'h5900_0000, 32'h0000_0000, 32'h0000_0006, 1'b0},
	// Timer compare read back
	'{PORT_B, RW_WRITE, 32'h5500_0004, 32'h0BAD_F00D, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_READ, 32'h5500_0004, 32'h0000_0000, 32'h0BAD_F00D, 1'b0},
	// Unmapped region and unmapped device
	'{PORT_A, RW_READ, 32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_READ, 32'h5100_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_WRITE, 32'h7000_0010, 32'h5A5A_5A5A, 32'h0000_0000, 1'b0},
	'{PORT_B, RW_READ, 32'h2000_0010, 32'h0000_0000, 32'hCAFE_0001, 1'b0}
};

`endif

/* sim/soc_tb.sv */
`timescale 1ns/1ns

module soc_tb;

	`include "soc_tb_table.svh"

	localparam int FREQUENCY = 10_000_000;
	localparam int RAM_ADDR_BITS = 10;
	localparam int DEVICE_ID = 6;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_WRITES = 32;
	localparam int RANDOM_SEED = 9;
	localparam int IRQ_WAIT_CYCLES = 60;
	localparam int TIMEOUT_CYCLES = TABLE_LEN * 12 + RANDOM_WRITES * 2 * 12 + 400 + RESET_CYCLES;

	localparam logic [31:0] RAM_BASE = 32'h2000_0000;
	localparam logic [31:0] RAM_OFFSET_MASK = 32'h0000_0FFC;
	localparam logic [31:0] LED_ADDRESS = 32'h5900_0008;
	localparam logic [31:0] TIMER_COUNT_ADDR = 32'h5500_0000;
	localparam logic [31:0] TIMER_COMPARE_ADDR = 32'h5500_0004;
	localparam logic [31:0] TIMER_CONTROL_ADDR = 32'h5500_0008;

	logic clock;
	logic reset;
	logic pa_request;
	logic [31:0] pa_address;
	logic [31:0] pa_rdata;
	logic pa_ready;
	logic pb_request;
	logic pb_rw;
	logic [31:0] pb_address;
	logic [31:0] pb_wdata;
	logic [31:0] pb_rdata;
	logic pb_ready;
	logic timer_interrupt;
	logic [7:0] leds;

	int cycle_count = 0;
	logic [31:0] ram_model [2**RAM_ADDR_BITS];
	logic [31:0] rand_addr [RANDOM_WRITES];

	soc_top #(
		.FREQUENCY(FREQUENCY),
		.RAM_ADDR_BITS(RAM_ADDR_BITS),
		.DEVICE_ID(DEVICE_ID)
	) uut(
		.clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_rdata(pa_rdata),
		.o_pa_ready(pa_ready),
		.i_pb_request(pb_request),
		.i_pb_rw(pb_rw),
		.i_pb_address(pb_address),
		.i_pb_wdata(pb_wdata),
		.o_pb_rdata(pb_rdata),
		.o_pb_ready(pb_ready),
		.o_timer_interrupt(timer_interrupt),
		.o_leds(leds)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Guard against a hung handshake
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("TEST FAIL");
			$fatal(1, "Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "Value check failed");
		end
	endtask

	// ====================
	// Master ports
	// ====================

	task automatic read_port_a(input logic [31:0] address, output logic [31:0] rdata);
		@(posedge clock);
		pa_request <= 1'b1;
		pa_address <= address;
		do
			@(negedge clock);
		while (!pa_ready);
		rdata = pa_rdata;
		@(posedge clock);
		pa_request <= 1'b0;
	endtask

	task automatic access_port_b(input logic rw, input logic [31:0] address,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clock);
		pb_request <= 1'b1;
		pb_rw <= rw;
		pb_address <= address;
		pb_wdata <= wdata;
		do
			@(negedge clock);
		while (!pb_ready);
		rdata = pb_rdata;
		@(posedge clock);
		pb_request <= 1'b0;
	endtask

	task automatic run_entry(input int index);
		stim_entry_t entry;
		logic [31:0] rdata;
		string label;
		entry = STIMULUS[index];
		label = $sformatf("table entry %0d", index);
		if (entry.port == PORT_A)
			read_port_a(entry.address, rdata);
		else
			access_port_b(entry.rw, entry.address, entry.wdata, rdata);
		if (entry.rw == RW_READ)
			check_value(rdata, entry.expected, label);
		else if (entry.address == LED_ADDRESS)
			check_value({24'd0, leds}, {24'd0, entry.wdata[7:0]}, "LED pins");
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		int i;
		int n;
		logic [31:0] rdata;
		logic [31:0] count_first;
		logic [31:0] count_second;

		void'($urandom(RANDOM_SEED));
		reset <= 1'b1;
		pa_request <= 1'b0;
		pa_address <= '0;
		pb_request <= 1'b0;
		pb_rw <= 1'b0;
		pb_address <= '0;
		pb_wdata <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value(32'(pa_ready), 32'd0, "port A ready after reset");
		check_value(32'(pb_ready), 32'd0, "port B ready after reset");
		check_value(32'(timer_interrupt), 32'd0, "timer interrupt after reset");
		check_value({24'd0, leds}, 32'd0, "LEDs after reset");

		i = 0;
		while (i < TABLE_LEN) begin
			if (STIMULUS[i].paired) begin
				fork
					run_entry(i);
					run_entry(i + 1);
				join
				i = i + 2;
			end else begin
				run_entry(i);
				i = i + 1;
			end
		end

		// Random words are read back after all writes so overlaps keep the last value
		for (n = 0; n < RANDOM_WRITES; n++) begin
			rand_addr[n] = RAM_BASE | ($urandom() & RAM_OFFSET_MASK);
			rdata = $urandom();
			ram_model[rand_addr[n][RAM_ADDR_BITS+1:2]] = rdata;
			access_port_b(RW_WRITE, rand_addr[n], rdata, count_first);
		end
		for (n = 0; n < RANDOM_WRITES; n++) begin
			access_port_b(RW_READ, rand_addr[n], 32'd0, rdata);
			check_value(rdata, ram_model[rand_addr[n][RAM_ADDR_BITS+1:2]],
				$sformatf("random read at %h", rand_addr[n]));
		end

		// Timer count and compare interrupt
		access_port_b(RW_READ, TIMER_COUNT_ADDR, 32'd0, count_first);
		access_port_b(RW_READ, TIMER_COUNT_ADDR, 32'd0, count_second);
		check_value(32'(count_second >= count_first), 32'd1, "timer count non-decreasing");
		access_port_b(RW_WRITE, TIMER_COMPARE_ADDR, count_second + 32'd3, rdata);
		access_port_b(RW_WRITE, TIMER_CONTROL_ADDR, 32'd1, rdata);
		n = 0;
		while (!timer_interrupt && n < IRQ_WAIT_CYCLES) begin
			@(negedge clock);
			n = n + 1;
		end
		check_value(32'(timer_interrupt), 32'd1, "timer interrupt raised");
		access_port_b(RW_WRITE, TIMER_COMPARE_ADDR, 32'hFFFF_FFFF, rdata);
		check_value(32'(timer_interrupt), 32'd0, "timer interrupt cleared");

		$display("TEST PASS");
		$finish;
	end

endmodule
